// File: design/dcuParams.svh
// Data array widths and depth

`ifndef DCU_PARAMS_SVH
`define DCU_PARAMS_SVH

// Array geometry
`define DCU_ADDR_W      9
`define DCU_DEPTH       512

// Data path widths
`define DCU_WORD_W      64
`define DCU_LINE_W      128
`define DCU_HALF_W      16

// Byte enable counts
`define DCU_SIDE_BYTES  8
`define DCU_LINE_BYTES  16

`endif

// File: design/dcuPkg.sv
// Data array vector types

`include "dcuParams.svh"

package dcuPkg;

  // ************************************************************************
  // Vector types, bit 0 is the most significant bit
  // ************************************************************************

  // Line index into the array
  typedef logic [0:`DCU_ADDR_W-1] addrT;

  // Word from the core, copied into both sides
  typedef logic [0:`DCU_WORD_W-1] wordT;

  // One full RAM line, side A then side B
  typedef logic [0:`DCU_LINE_W-1] lineT;

  // One output halfword
  typedef logic [0:`DCU_HALF_W-1] halfT;

  // Byte enables
  typedef logic [0:`DCU_SIDE_BYTES-1] sideMaskT;
  typedef logic [0:`DCU_LINE_BYTES-1] lineMaskT;

endpackage

// File: design/dcuWriteSteer.sv
// Data array write steering

`timescale 1ns/100ps

`include "dcuParams.svh"

module dcuWriteSteer
(
  input  dcuPkg::wordT     dataIn,
  input  dcuPkg::sideMaskT byteWriteA,
  input  dcuPkg::sideMaskT byteWriteB,
  output dcuPkg::lineT     wrLine,
  output dcuPkg::lineMaskT wrMask
);

  localparam int HalvesPerWord = `DCU_WORD_W / `DCU_HALF_W;

  // **************************************************************************
  // Data lanes
  // **************************************************************************

  // Input halfword k-1 lands on Ak and on Bk
  always_comb
  begin
    wrLine = '0;
    for (int h = 0; h < HalvesPerWord; h++)
    begin
      // Side A
      wrLine[h*`DCU_HALF_W +: `DCU_HALF_W] =
        dataIn[h*`DCU_HALF_W +: `DCU_HALF_W];
      // Side B, one word further along the line
      wrLine[`DCU_WORD_W + h*`DCU_HALF_W +: `DCU_HALF_W] =
        dataIn[h*`DCU_HALF_W +: `DCU_HALF_W];
    end
  end

  // **************************************************************************
  // Byte enables
  // **************************************************************************

  // Line bytes 0 to 7 belong to side A, 8 to 15 to side B
  always_comb
  begin
    wrMask = '0;
    for (int b = 0; b < `DCU_SIDE_BYTES; b++)
    begin
      wrMask[b]                   = byteWriteA[b];
      wrMask[`DCU_SIDE_BYTES + b] = byteWriteB[b];
    end
  end

endmodule

// File: design/dcuDataRam.sv
// Data array storage

`timescale 1ns/100ps

`include "dcuParams.svh"

module dcuDataRam
(
  input  logic             cclk,
  input  logic             ramCeN,
  input  logic             readWrite,
  input  dcuPkg::addrT     addr,
  input  dcuPkg::lineT     wrLine,
  input  dcuPkg::lineMaskT wrMask,
  output dcuPkg::lineT     rdLine
);

  localparam int ByteW = `DCU_LINE_W / `DCU_LINE_BYTES;

  dcuPkg::lineT mem [0:`DCU_DEPTH-1];

  logic doRead;
  logic doWrite;

  // Strobe decode
  assign doRead  = ~ramCeN & readWrite;
  assign doWrite = ~ramCeN & ~readWrite;

  // **************************************************************************
  // Array write with byte merge
  // **************************************************************************

  always_ff @(posedge cclk)
  begin
    if (doWrite)
    begin
      for (int b = 0; b < `DCU_LINE_BYTES; b++)
      begin
        // Disabled bytes keep their old contents
        if (wrMask[b])
        begin
          mem[addr][b*ByteW +: ByteW] <= wrLine[b*ByteW +: ByteW];
        end
      end
    end
  end

  // **************************************************************************
  // Registered read
  // **************************************************************************

  // Output register only moves on a read
  always_ff @(posedge cclk)
  begin
    if (doRead)
    begin
      rdLine <= mem[addr];
    end
  end

  // Address must be valid on every strobed access
  addrKnownA: assert property (@(posedge cclk)
    !ramCeN |-> !$isunknown(addr))
    else $error("dcuDataRam: unknown address on a strobed access");

  // Enables come through the steering stage
  maskKnownA: assert property (@(posedge cclk)
    (!ramCeN && !readWrite) |-> !$isunknown(wrMask))
    else $error("dcuDataRam: unknown byte enables on a write");

endmodule

// File: design/dcuReadHold.sv
// Read data hold across writes

`timescale 1ns/100ps

module dcuReadHold
(
  input  logic         cclk,
  input  logic         arstN,
  input  logic         ramCeN,
  input  logic         readWrite,
  input  dcuPkg::lineT rdLine,
  output dcuPkg::lineT outLine
);

  logic         readMode;
  logic         captureEn;
  dcuPkg::lineT heldLine;

  // Leaving read mode freezes the last read line
  assign captureEn = readMode & ~readWrite;

  // **************************************************************************
  // Access type tracking
  // **************************************************************************

  // Any edge with readWrite low ends read mode even without a strobe
  always_ff @(posedge cclk or negedge arstN)
  begin
    if (!arstN)
    begin
      readMode <= 1'b0;
    end
    else if (!readWrite)
    begin
      readMode <= 1'b0;
    end
    else if (!ramCeN)
    begin
      readMode <= 1'b1;
    end
  end

  // **************************************************************************
  // Held line
  // **************************************************************************

  always_ff @(posedge cclk or negedge arstN)
  begin
    if (!arstN)
    begin
      heldLine <= '0;
    end
    else if (captureEn)
    begin
      heldLine <= rdLine;
    end
  end

  // Live RAM data while reading, frozen copy otherwise
  assign outLine = readMode ? rdLine : heldLine;

  // Output keeps the last read line across every write edge
  holdStableA: assert property (@(posedge cclk) disable iff (!arstN)
    !readWrite |=> $stable(outLine))
    else $error("dcuReadHold: output line moved across a write edge");

endmodule

// File: design/dcuDataArray.sv
// Data cache data array

`timescale 1ns/100ps

`include "dcuParams.svh"

module dcuDataArray
(
  input  logic             cclk,
  input  logic             arstN,
  input  logic             ramCeN,
  input  logic             readWrite,
  input  dcuPkg::addrT     addr,
  input  dcuPkg::wordT     dataIn,
  input  dcuPkg::sideMaskT byteWriteA,
  input  dcuPkg::sideMaskT byteWriteB,
  output dcuPkg::halfT     dataOutA1,
  output dcuPkg::halfT     dataOutA2,
  output dcuPkg::halfT     dataOutA3,
  output dcuPkg::halfT     dataOutA4,
  output dcuPkg::halfT     dataOutB1,
  output dcuPkg::halfT     dataOutB2,
  output dcuPkg::halfT     dataOutB3,
  output dcuPkg::halfT     dataOutB4
);

  // Side B starts one word into the line
  localparam int SideBOfs = `DCU_WORD_W;

  dcuPkg::lineT     wrLine;
  dcuPkg::lineMaskT wrMask;
  dcuPkg::lineT     rdLine;
  dcuPkg::lineT     outLine;

  // **************************************************************************
  // Write steering
  // **************************************************************************

  dcuWriteSteer writeSteer
  (
    .dataIn     (dataIn),
    .byteWriteA (byteWriteA),
    .byteWriteB (byteWriteB),
    .wrLine     (wrLine),
    .wrMask     (wrMask)
  );

  // **************************************************************************
  // Storage
  // **************************************************************************

  dcuDataRam dataRam
  (
    .cclk      (cclk),
    .ramCeN    (ramCeN),
    .readWrite (readWrite),
    .addr      (addr),
    .wrLine    (wrLine),
    .wrMask    (wrMask),
    .rdLine    (rdLine)
  );

  // **************************************************************************
  // Read hold
  // **************************************************************************

  dcuReadHold readHold
  (
    .cclk      (cclk),
    .arstN     (arstN),
    .ramCeN    (ramCeN),
    .readWrite (readWrite),
    .rdLine    (rdLine),
    .outLine   (outLine)
  );

  // Halfword slicing, A1 holds line bytes 0 and 1
  assign dataOutA1 = outLine[0*`DCU_HALF_W +: `DCU_HALF_W];
  assign dataOutA2 = outLine[1*`DCU_HALF_W +: `DCU_HALF_W];
  assign dataOutA3 = outLine[2*`DCU_HALF_W +: `DCU_HALF_W];
  assign dataOutA4 = outLine[3*`DCU_HALF_W +: `DCU_HALF_W];

  // Same layout on side B
  assign dataOutB1 = outLine[SideBOfs + 0*`DCU_HALF_W +: `DCU_HALF_W];
  assign dataOutB2 = outLine[SideBOfs + 1*`DCU_HALF_W +: `DCU_HALF_W];
  assign dataOutB3 = outLine[SideBOfs + 2*`DCU_HALF_W +: `DCU_HALF_W];
  assign dataOutB4 = outLine[SideBOfs + 3*`DCU_HALF_W +: `DCU_HALF_W];

endmodule

// File: dv/dcuClockGen.sv
// Testbench clock and reset

`timescale 1ns/100ps

module dcuClockGen
#(
  parameter int ResetCycles  = 8,
  parameter int HalfPeriodNs = 10
)
(
  output logic cclk,
  output logic arstN
);

  // Free-running clock
  initial
  begin
    cclk = 1'b0;
    forever
    begin
      #(HalfPeriodNs) cclk = ~cclk;
    end
  end

  // Reset held low for the first cycles, released on a falling edge
  initial
  begin
    arstN = 1'b0;
    repeat (ResetCycles) @(posedge cclk);
    @(negedge cclk);
    arstN = 1'b1;
  end

endmodule

// File: dv/dcuTbTasks.svh
// Data array testbench tasks

// ****************************************************************************
// Model and bus access
// ****************************************************************************

// Input byte j goes to line byte j of side A and line byte 8+j of side B
function automatic dcuPkg::lineT mergeLine(input dcuPkg::lineT oldLine,
                                           input dcuPkg::wordT word,
                                           input dcuPkg::sideMaskT maskA,
                                           input dcuPkg::sideMaskT maskB);
  dcuPkg::lineT result;
  result = oldLine;
  for (int j = 0; j < `DCU_SIDE_BYTES; j++)
  begin
    if (maskA[j])
    begin
      result[j*8 +: 8] = word[j*8 +: 8];
    end
    if (maskB[j])
    begin
      result[`DCU_WORD_W + j*8 +: 8] = word[j*8 +: 8];
    end
  end
  return result;
endfunction

// Called on a falling edge, returns on a falling edge
task automatic doWrite(input dcuPkg::addrT a, input dcuPkg::wordT word,
                       input dcuPkg::sideMaskT maskA, input dcuPkg::sideMaskT maskB);
  ramCeN     = 1'b0;
  readWrite  = 1'b0;
  addr       = a;
  dataIn     = word;
  byteWriteA = maskA;
  byteWriteB = maskB;
  @(negedge cclk);
  ramCeN = 1'b1;
  @(negedge cclk);
  model[a] = mergeLine(model[a], word, maskA, maskB);
endtask

task automatic doRead(input dcuPkg::addrT a);
  ramCeN    = 1'b0;
  readWrite = 1'b1;
  addr      = a;
  @(negedge cclk);
  ramCeN = 1'b1;
  @(negedge cclk);
endtask

// ****************************************************************************
// Compare
// ****************************************************************************

// Lanes 0 to 3 are A1 to A4, lanes 4 to 7 are B1 to B4
function automatic dcuPkg::halfT outHalf(input int lane);
  case (lane)
    0: return dataOutA1;
    1: return dataOutA2;
    2: return dataOutA3;
    3: return dataOutA4;
    4: return dataOutB1;
    5: return dataOutB2;
    6: return dataOutB3;
    default: return dataOutB4;
  endcase
endfunction

function automatic string laneName(input int lane);
  return $sformatf("%s%0d", (lane < 4) ? "A" : "B", (lane % 4) + 1);
endfunction

task automatic checkHalf(input string testName, input string lane,
                         input dcuPkg::halfT expected, input dcuPkg::halfT actual);
  checkCount++;
  if (actual !== expected)
  begin
    errorCount++;
    $display("Fail %s lane %s expected %h actual %h", testName, lane, expected, actual);
  end
endtask

task automatic checkLine(input string testName, input dcuPkg::lineT expected);
  for (int lane = 0; lane < 8; lane++)
  begin
    checkHalf(testName, laneName(lane), expected[lane*`DCU_HALF_W +: `DCU_HALF_W],
              outHalf(lane));
  end
endtask

// ****************************************************************************
// Directed tests
// ****************************************************************************

task automatic testReset();
  dcuPkg::lineT zeroLine;
  zeroLine = '0;
  checkLine("reset", zeroLine);
  // No read yet, so a write stays invisible
  doWrite(9'h003, 64'h0123_4567_89AB_CDEF, 8'hFF, 8'hFF);
  checkLine("reset", zeroLine);
endtask

task automatic testFullWrite();
  dcuPkg::addrT addrs [4];
  dcuPkg::wordT words [4];
  addrs = '{9'h000, 9'h055, 9'h1AA, 9'h1FF};
  words = '{64'hDEAD_BEEF_0BAD_F00D, 64'h0001_0203_0405_0607,
            64'hFFFF_0000_A5A5_5A5A, 64'h1234_5678_9ABC_DEF0};
  for (int i = 0; i < 4; i++)
  begin
    doWrite(addrs[i], words[i], 8'hFF, 8'hFF);
  end
  for (int i = 0; i < 4; i++)
  begin
    doRead(addrs[i]);
    // Ak and Bk both carry input halfword k-1
    for (int lane = 0; lane < 8; lane++)
    begin
      checkHalf("fullWrite", laneName(lane),
                words[i][(lane % 4)*`DCU_HALF_W +: `DCU_HALF_W], outHalf(lane));
    end
  end
endtask

task automatic testByteMerge();
  doWrite(9'h0A5, 64'h1111_2222_3333_4444, 8'hFF, 8'hFF);
  doWrite(9'h0A5, 64'hAAAA_BBBB_CCCC_DDDD, 8'hA5, 8'h3C);
  doRead(9'h0A5);
  checkLine("byteMerge", model[9'h0A5]);
  doWrite(9'h0A5, 64'h5555_6666_7777_8888, 8'h0F, 8'hF0);
  // No enables, line must not move
  doWrite(9'h0A5, 64'hFFFF_FFFF_FFFF_FFFF, 8'h00, 8'h00);
  doRead(9'h0A5);
  checkLine("byteMerge", model[9'h0A5]);
endtask

task automatic testSideIndependence();
  doWrite(9'h0C0, 64'h0F0F_1E1E_2D2D_3C3C, 8'hFF, 8'hFF);
  doWrite(9'h0C0, 64'h9999_8888_7777_6666, 8'h00, 8'hFF);
  doRead(9'h0C0);
  checkLine("sideBOnly", model[9'h0C0]);
  doWrite(9'h0C1, 64'h4B4B_5A5A_6969_7878, 8'hFF, 8'hFF);
  doWrite(9'h0C1, 64'h3333_2222_1111_0000, 8'hFF, 8'h00);
  doRead(9'h0C1);
  checkLine("sideAOnly", model[9'h0C1]);
endtask

task automatic testHoldDuringWrites();
  dcuPkg::addrT others [3];
  others = '{9'h021, 9'h022, 9'h023};
  doWrite(9'h020, 64'hC0FF_EE00_FACE_B00C, 8'hFF, 8'hFF);
  doRead(9'h020);
  checkLine("hold", model[9'h020]);
  for (int i = 0; i < 3; i++)
  begin
    doWrite(others[i], {nextRand(), nextRand()}, 8'hFF, 8'hFF);
    checkLine("hold", model[9'h020]);
  end
  doRead(9'h022);
  checkLine("holdNewRead", model[9'h022]);
endtask

task automatic testRandom();
  dcuPkg::addrT pool [$];
  bit           seen [0:`DCU_DEPTH-1];
  int unsigned  ctl;
  int unsigned  maskBits;
  int           idx;
  dcuPkg::addrT a;
  dcuPkg::wordT word;
  for (int n = 0; n < RandomAccesses; n++)
  begin
    ctl = nextRand();
    if (ctl[24] && pool.size() > 0)
    begin
      idx = (ctl >> 8) % pool.size();
      a = pool[idx];
      doRead(a);
      checkLine("random", model[a]);
    end
    else
    begin
      a = {5'b10000, ctl[19:16]};
      word = {nextRand(), nextRand()};
      maskBits = nextRand();
      if (seen[a])
      begin
        doWrite(a, word, maskBits[23:16], maskBits[31:24]);
      end
      else
      begin
        // First write to a line fills it completely
        doWrite(a, word, 8'hFF, 8'hFF);
        seen[a] = 1'b1;
        pool.push_back(a);
      end
    end
  end
endtask

// File: dv/dcuDataArrayTb.sv
// Data array testbench

`timescale 1ns/100ps

`include "dcuParams.svh"

module dcuDataArrayTb;

  localparam int ClkPeriodNs     = 20;
  localparam int ResetCycles     = 8;
  localparam int CyclesPerAccess = 2;

  // Strobed accesses per directed test
  localparam int ResetAccesses  = 1;
  localparam int FullAccesses   = 8;
  localparam int MergeAccesses  = 6;
  localparam int SideAccesses   = 6;
  localparam int HoldAccesses   = 6;
  localparam int RandomAccesses = 40;

  localparam int NumAccesses = ResetAccesses + FullAccesses + MergeAccesses +
                               SideAccesses + HoldAccesses + RandomAccesses;
  localparam int TestCycles  = ResetCycles + 2 + CyclesPerAccess * NumAccesses;
  localparam int WatchdogNs  = TestCycles * ClkPeriodNs * 2;

  logic              cclk;
  logic              arstN;
  logic              ramCeN;
  logic              readWrite;
  dcuPkg::addrT      addr;
  dcuPkg::wordT      dataIn;
  dcuPkg::sideMaskT  byteWriteA;
  dcuPkg::sideMaskT  byteWriteB;
  dcuPkg::halfT      dataOutA1;
  dcuPkg::halfT      dataOutA2;
  dcuPkg::halfT      dataOutA3;
  dcuPkg::halfT      dataOutA4;
  dcuPkg::halfT      dataOutB1;
  dcuPkg::halfT      dataOutB2;
  dcuPkg::halfT      dataOutB3;
  dcuPkg::halfT      dataOutB4;

  // Expected contents of every line
  dcuPkg::lineT model [0:`DCU_DEPTH-1];

  int          errorCount = 0;
  int          checkCount = 0;
  int unsigned lcgState   = 52;

  dcuClockGen
  #(
    .ResetCycles  (ResetCycles),
    .HalfPeriodNs (ClkPeriodNs / 2)
  )
  clockGen
  (
    .cclk  (cclk),
    .arstN (arstN)
  );

  dcuDataArray dcuDataArray_inst
  (
    .cclk       (cclk),
    .arstN      (arstN),
    .ramCeN     (ramCeN),
    .readWrite  (readWrite),
    .addr       (addr),
    .dataIn     (dataIn),
    .byteWriteA (byteWriteA),
    .byteWriteB (byteWriteB),
    .dataOutA1  (dataOutA1),
    .dataOutA2  (dataOutA2),
    .dataOutA3  (dataOutA3),
    .dataOutA4  (dataOutA4),
    .dataOutB1  (dataOutB1),
    .dataOutB2  (dataOutB2),
    .dataOutB3  (dataOutB3),
    .dataOutB4  (dataOutB4)
  );

  // Linear congruential generator for addresses, data and masks
  function automatic int unsigned nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  `include "dcuTbTasks.svh"

  // **************************************************************************
  // Test sequence
  // **************************************************************************

  initial
  begin
    ramCeN     = 1'b1;
    readWrite  = 1'b1;
    addr       = '0;
    dataIn     = '0;
    byteWriteA = '0;
    byteWriteB = '0;
    @(posedge arstN);
    @(negedge cclk);

    testReset();
    testFullWrite();
    testByteMerge();
    testSideIndependence();
    testHoldDuringWrites();
    testRandom();

    $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
    begin
      $display("All checks passed");
    end
    else
    begin
      $display("Checks failed");
    end
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WatchdogNs);
    $display("Timeout: the tests did not finish within %0d ns", WatchdogNs);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: flist.f
+incdir+design
+incdir+dv
design/dcuPkg.sv
design/dcuWriteSteer.sv
design/dcuDataRam.sv
design/dcuReadHold.sv
design/dcuDataArray.sv
dv/dcuClockGen.sv
dv/dcuDataArrayTb.sv

// File: run.sh
#!/bin/sh
# Build and run the data array testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=dcuDataArrayTb

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module dcuDataArrayTb \
  --Mdir "$OBJ" -o "$BIN" \
  -f flist.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi

echo "Pass message not found in $LOG"
exit 1
